// File: hdl/pkt_fifo_pkg.sv
package pkt_fifo_pkg;

   // ------------------------------
   // stream word geometry
   // ------------------------------

   // bytes carried by one stream word
   localparam int DATA_BYTES = 4;

   // width of a single tdata byte lane
   localparam int BYTE_WID = 8;

   // ------------------------------
   // storage geometry
   // ------------------------------

   // words of packet storage, must be a power of two
   localparam int FIFO_DEPTH = 64;

   // memory address bits
   localparam int ADDR_WID = $clog2(FIFO_DEPTH);

   // address plus one wrap bit, so full and empty differ
   localparam int PTR_WID = ADDR_WID + 1;

   // occupancy and threshold width, holds 0 up to FIFO_DEPTH
   localparam int CNT_WID = $clog2(FIFO_DEPTH + 1);

   // width of the dropped-packet counter
   localparam int DROP_CNT_WID = 16;

   // ------------------------------
   // stored word
   // ------------------------------

   // tlast sits on top so a word dump reads packet boundaries first
   typedef struct packed {
      logic                                tlast;
      logic [DATA_BYTES-1:0]               tkeep;
      logic [DATA_BYTES-1:0][BYTE_WID-1:0] tdata;
   } pkt_word_t;

   // ------------------------------
   // ingress classification
   // ------------------------------

   // ING_IDLE  between packets
   // ING_PASS  inside a packet that is being stored
   // ING_DROP  discarding the tail of an overflowed packet
   typedef enum logic [1:0] {
      ING_IDLE = 2'd0,
      ING_PASS = 2'd1,
      ING_DROP = 2'd2
   } ing_state_t;

endpackage

// File: hdl/pkt_gray_sync.sv
`timescale 1ns/1ps

module pkt_gray_sync (
   input  logic                             clk_dst,
   input  logic                             rst_n,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0] ptr_src,
   output logic [pkt_fifo_pkg::PTR_WID-1:0] ptr_dst
);
   import pkt_fifo_pkg::*;

   logic [PTR_WID-1:0] gray_src;
   logic [PTR_WID-1:0] gray_meta;
   logic [PTR_WID-1:0] gray_sync;

   function automatic logic [PTR_WID-1:0] gray_to_bin(input logic [PTR_WID-1:0] g);
      logic [PTR_WID-1:0] b;
      b[PTR_WID-1] = g[PTR_WID-1];
      for (int i = PTR_WID - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // binary to gray on the source side
   assign gray_src = ptr_src ^ (ptr_src >> 1);

   // two flops into clk_dst, then a registered decode
   always_ff @(posedge clk_dst) begin
      if (!rst_n) begin
         gray_meta <= '0;
         gray_sync <= '0;
         ptr_dst   <= '0;
      end else begin
         gray_meta <= gray_src;
         gray_sync <= gray_meta;
         ptr_dst   <= gray_to_bin(gray_sync);
      end
   end

endmodule

// File: hdl/pkt_dual_clock_mem.sv
`timescale 1ns/1ps

module pkt_dual_clock_mem (
   input  logic                             clk_in,
   input  logic                             clk_out,
   input  logic                             rst_n,
   input  logic                             wr_en,
   input  pkt_fifo_pkg::pkt_word_t          wr_word,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0] wr_ptr,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0] commit_ptr,
   input  logic                             rd_en,
   output logic [pkt_fifo_pkg::PTR_WID-1:0] rd_ptr_wr,
   output pkt_fifo_pkg::pkt_word_t          mem_word,
   output logic                             avail,
   output logic                             rst_out_n
);
   import pkt_fifo_pkg::*;

   pkt_word_t            word_mem [FIFO_DEPTH];

   logic [PTR_WID-1:0]   rd_ptr;
   logic [PTR_WID-1:0]   commit_rd;
   logic                 rst_meta_n;

   // ------------------------------
   // read-domain reset
   // ------------------------------

   // rst_n is released into clk_out through two flops
   always_ff @(posedge clk_out) begin
      rst_meta_n <= rst_n;
      rst_out_n  <= rst_meta_n;
   end

   // ------------------------------
   // word storage
   // ------------------------------

   // speculative words land here too, they stay invisible until committed
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         word_mem[wr_ptr[ADDR_WID-1:0]] <= wr_word;
      end
   end

   // head word is always presented, the egress decides when to take it
   assign mem_word = word_mem[rd_ptr[ADDR_WID-1:0]];

   // ------------------------------
   // read pointer
   // ------------------------------

   always_ff @(posedge clk_out) begin
      if (!rst_out_n) begin
         rd_ptr <= '0;
      end else if (rd_en) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // any committed word not yet read
   assign avail = (commit_rd != rd_ptr);

   // ------------------------------
   // pointer exchange
   // ------------------------------

   // commit pointer into the read domain
   pkt_gray_sync commit_sync (
      .clk_dst (clk_out),
      .rst_n   (rst_out_n),
      .ptr_src (commit_ptr),
      .ptr_dst (commit_rd)
   );

   // read pointer back into the write domain, frees space for the ingress
   pkt_gray_sync read_sync (
      .clk_dst (clk_in),
      .rst_n   (rst_n),
      .ptr_src (rd_ptr),
      .ptr_dst (rd_ptr_wr)
   );

   // the egress may only pull words that the ingress already committed
   a_no_read_when_empty: assert property (@(posedge clk_out) disable iff (!rst_out_n)
      rd_en |-> avail);

endmodule

// File: hdl/pkt_ingress_discard.sv
`timescale 1ns/1ps

module pkt_ingress_discard (
   input  logic                                  clk_in,
   input  logic                                  rst_n,
   input  logic                                  in_valid,
   input  pkt_fifo_pkg::pkt_word_t               in_word,
   input  logic [pkt_fifo_pkg::PTR_WID-1:0]      rd_ptr_wr,
   input  logic [pkt_fifo_pkg::CNT_WID-1:0]      flow_ctl_thresh,
   output logic                                  wr_en,
   output pkt_fifo_pkg::pkt_word_t               wr_word,
   output logic [pkt_fifo_pkg::PTR_WID-1:0]      wr_ptr,
   output logic [pkt_fifo_pkg::PTR_WID-1:0]      commit_ptr,
   output logic                                  flow_ctl,
   output logic [pkt_fifo_pkg::DROP_CNT_WID-1:0] drop_count
);
   import pkt_fifo_pkg::*;

   ing_state_t           state;
   ing_state_t           state_nxt;

   logic [PTR_WID-1:0]   spec_occ;
   logic [PTR_WID-1:0]   wr_lead;
   logic [CNT_WID-1:0]   commit_occ;
   logic                 spec_full;
   logic                 drop_start;

   // ------------------------------
   // occupancy as seen from clk_in
   // ------------------------------

   // speculative fill includes words of the packet still being received
   assign spec_occ   = wr_ptr - rd_ptr_wr;
   assign spec_full  = (spec_occ == PTR_WID'(FIFO_DEPTH));

   // committed fill only counts complete packets
   assign commit_occ = commit_ptr - rd_ptr_wr;

   // distance between the speculative and committed write pointers
   assign wr_lead    = wr_ptr - commit_ptr;

   // ------------------------------
   // word classification
   // ------------------------------

   assign wr_en      = in_valid && !spec_full && (state != ING_DROP);
   assign drop_start = in_valid && spec_full && (state != ING_DROP);
   assign wr_word    = in_word;

   always_comb begin
      state_nxt = state;
      case (state)
         ING_IDLE, ING_PASS: begin
            if (in_valid) begin
               if (in_word.tlast) begin
                  state_nxt = ING_IDLE;
               end else if (spec_full) begin
                  state_nxt = ING_DROP;
               end else begin
                  state_nxt = ING_PASS;
               end
            end
         end
         ING_DROP: begin
            // wait for the end of the discarded packet
            if (in_valid && in_word.tlast) begin
               state_nxt = ING_IDLE;
            end
         end
         default: begin
            state_nxt = ING_IDLE;
         end
      endcase
   end

   // ------------------------------
   // pointers, commit and rewind
   // ------------------------------

   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         state      <= ING_IDLE;
         wr_ptr     <= '0;
         commit_ptr <= '0;
         drop_count <= '0;
      end else begin
         state <= state_nxt;
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            // publish the packet once its last word is stored
            if (in_word.tlast) begin
               commit_ptr <= wr_ptr + 1'b1;
            end
         end else if (drop_start) begin
            // forget every word of the partial packet
            wr_ptr     <= commit_ptr;
            drop_count <= drop_count + 1'b1;
         end
      end
   end

   // flow control tracks committed data only
   always_ff @(posedge clk_in) begin
      if (!rst_n) begin
         flow_ctl <= 1'b0;
      end else begin
         flow_ctl <= (commit_occ > flow_ctl_thresh);
      end
   end

   a_commit_not_ahead: assert property (@(posedge clk_in) disable iff (!rst_n)
      wr_lead <= PTR_WID'(FIFO_DEPTH));

   a_occ_in_range: assert property (@(posedge clk_in) disable iff (!rst_n)
      spec_occ <= PTR_WID'(FIFO_DEPTH));

endmodule

// File: hdl/pkt_egress.sv
`timescale 1ns/1ps

module pkt_egress (
   input  logic                    clk_out,
   input  logic                    rst_out_n,
   input  logic                    avail,
   input  pkt_fifo_pkg::pkt_word_t mem_word,
   input  logic                    out_ready,
   output logic                    rd_en,
   output logic                    out_valid,
   output pkt_fifo_pkg::pkt_word_t out_word
);

   logic out_free;

   // ------------------------------
   // output register control
   // ------------------------------

   // register can take a new word when empty or when its word leaves now
   assign out_free = !out_valid || out_ready;

   // one read pulse per word moved into the register
   assign rd_en = avail && out_free;

   always_ff @(posedge clk_out) begin
      if (!rst_out_n) begin
         out_valid <= 1'b0;
      end else if (rd_en) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // ------------------------------
   // output payload
   // ------------------------------

   // held while the sink stalls
   always_ff @(posedge clk_out) begin
      if (rd_en) begin
         out_word <= mem_word;
      end
   end

   // a stalled word must not change or vanish
   a_hold_under_stall: assert property (@(posedge clk_out) disable iff (!rst_out_n)
      out_valid && !out_ready |=> out_valid && $stable(out_word));

endmodule

// File: hdl/pkt_fifo_async.sv
`timescale 1ns/1ps

module pkt_fifo_async (
   input  logic                                  clk_in,
   input  logic                                  clk_out,
   input  logic                                  rst_n,
   input  logic                                  in_valid,
   input  pkt_fifo_pkg::pkt_word_t               in_word,
   input  logic [pkt_fifo_pkg::CNT_WID-1:0]      flow_ctl_thresh,
   input  logic                                  out_ready,
   output logic                                  out_valid,
   output pkt_fifo_pkg::pkt_word_t               out_word,
   output logic                                  flow_ctl,
   output logic [pkt_fifo_pkg::DROP_CNT_WID-1:0] drop_count
);
   import pkt_fifo_pkg::*;

   // write-domain links
   logic                 wr_en;
   pkt_word_t            wr_word;
   logic [PTR_WID-1:0]   wr_ptr;
   logic [PTR_WID-1:0]   commit_ptr;
   logic [PTR_WID-1:0]   rd_ptr_wr;

   // read-domain links
   pkt_word_t            mem_word;
   logic                 avail;
   logic                 rd_en;
   logic                 rst_out_n;

   pkt_ingress_discard ingress (
      .clk_in          (clk_in),
      .rst_n           (rst_n),
      .in_valid        (in_valid),
      .in_word         (in_word),
      .rd_ptr_wr       (rd_ptr_wr),
      .flow_ctl_thresh (flow_ctl_thresh),
      .wr_en           (wr_en),
      .wr_word         (wr_word),
      .wr_ptr          (wr_ptr),
      .commit_ptr      (commit_ptr),
      .flow_ctl        (flow_ctl),
      .drop_count      (drop_count)
   );

   pkt_dual_clock_mem mem (
      .clk_in     (clk_in),
      .clk_out    (clk_out),
      .rst_n      (rst_n),
      .wr_en      (wr_en),
      .wr_word    (wr_word),
      .wr_ptr     (wr_ptr),
      .commit_ptr (commit_ptr),
      .rd_en      (rd_en),
      .rd_ptr_wr  (rd_ptr_wr),
      .mem_word   (mem_word),
      .avail      (avail),
      .rst_out_n  (rst_out_n)
   );

   pkt_egress egress (
      .clk_out   (clk_out),
      .rst_out_n (rst_out_n),
      .avail     (avail),
      .mem_word  (mem_word),
      .out_ready (out_ready),
      .rd_en     (rd_en),
      .out_valid (out_valid),
      .out_word  (out_word)
   );

endmodule

// File: verification/tb_pkt_fifo_async.sv
`timescale 1ns/1ps

module tb_pkt_fifo_async;
   import pkt_fifo_pkg::*;

   logic                    clk_in = 1'b0;
   logic                    clk_out = 1'b0;
   logic                    out_phase_done = 1'b0;
   logic                    rst_n;
   logic                    in_valid;
   pkt_word_t               in_word;
   logic [CNT_WID-1:0]      flow_ctl_thresh;
   logic                    out_ready;
   logic                    out_valid;
   pkt_word_t               out_word;
   logic                    flow_ctl;
   logic [DROP_CNT_WID-1:0] drop_count;

   // expected traffic and stimulus state
   logic [31:0]             lcg_state = 32'd17633;
   pkt_word_t               exp_q[$];
   pkt_word_t               pkt_buf[$];
   int                      stored_words;
   int                      exp_drops;
   logic                    track_occ;
   logic                    ready_random;
   logic                    held_valid;
   pkt_word_t               held_word;
   pkt_word_t               got_word;

   always #50 clk_in = ~clk_in;

   // clk_out lags clk_in by 30 ns
   always begin
      if (!out_phase_done) begin
         #30;
         out_phase_done = 1'b1;
      end
      #50 clk_out = ~clk_out;
   end

   pkt_fifo_async dut (
      .clk_in          (clk_in),
      .clk_out         (clk_out),
      .rst_n           (rst_n),
      .in_valid        (in_valid),
      .in_word         (in_word),
      .flow_ctl_thresh (flow_ctl_thresh),
      .out_ready       (out_ready),
      .out_valid       (out_valid),
      .out_word        (out_word),
      .flow_ctl        (flow_ctl),
      .drop_count      (drop_count)
   );

   // ------------------------------
   // helpers
   // ------------------------------

   function logic [31:0] lcg();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // full tkeep inside a packet and a shorter one on the last word
   function pkt_word_t make_word(input logic last);
      pkt_word_t   w;
      logic [31:0] r;
      r       = lcg();
      w.tlast = last;
      w.tdata = lcg();
      w.tkeep = last ? (4'hF >> r[31:30]) : 4'hF;
      return w;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s (time %0t)", msg, $time);
      $display("Result: FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH time %0t signal %s expected %h actual %h",
                  $time, name, expected, actual);
         report_failure("value check failed");
      end
   endtask

   task drive_word(input pkt_word_t w);
      @(posedge clk_in);
      #5;
      in_valid = 1'b1;
      in_word  = w;
   endtask

   task end_input();
      @(posedge clk_in);
      #5;
      in_valid = 1'b0;
      in_word  = '0;
   endtask

   // overflow rule for a stalled egress
   task queue_packet();
      int room;
      room = FIFO_DEPTH;
      // a stalled egress already holds one word in its output register
      if (stored_words > 0) begin
         room = FIFO_DEPTH + 1;
      end
      if (!track_occ || (stored_words + pkt_buf.size() <= room)) begin
         if (track_occ) begin
            stored_words += pkt_buf.size();
         end
         foreach (pkt_buf[i]) begin
            exp_q.push_back(pkt_buf[i]);
         end
      end else begin
         exp_drops++;
      end
      check_value("drop_count", exp_drops, drop_count);
   endtask

   task send_packet(input int len);
      pkt_word_t w;
      pkt_buf.delete();
      for (int i = 0; i < len; i++) begin
         w = make_word(i == len - 1);
         pkt_buf.push_back(w);
         drive_word(w);
      end
      end_input();
      queue_packet();
   endtask

   task set_ready(input logic value);
      ready_random = 1'b0;
      @(posedge clk_out);
      #5;
      out_ready = value;
   endtask

   task wait_idle(input string what);
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk_out);
         n++;
         if (n > 3000) begin
            report_failure({"timeout while waiting for delivery of ", what});
         end
      end
      // freed space reaches the ingress a few clk_in cycles later
      repeat (6) @(posedge clk_in);
   endtask

   task check_outputs_idle();
      check_value("out_valid", 0, out_valid);
      check_value("flow_ctl", 0, flow_ctl);
      check_value("drop_count", 0, drop_count);
   endtask

   // ------------------------------
   // sink side
   // ------------------------------

   always @(posedge clk_out) begin
      #5;
      if (ready_random) begin
         out_ready = (lcg() >= 32'h6000_0000);
      end
   end

   always @(posedge clk_out) begin
      if (held_valid) begin
         check_value("out_valid while stalled", 1, out_valid);
         check_value("out_word while stalled", held_word, out_word);
      end
      held_valid = out_valid && !out_ready;
      held_word  = out_word;
      if (out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            report_failure("a word was delivered while no packet was expected");
         end else begin
            got_word = exp_q.pop_front();
            check_value("out_word", got_word, out_word);
         end
      end
   end

   // ------------------------------
   // tests
   // ------------------------------

   task test_reset();
      rst_n = 1'b0;
      for (int i = 0; i < 8; i++) begin
         @(posedge clk_in);
         #5;
         check_value("flow_ctl", 0, flow_ctl);
         check_value("drop_count", 0, drop_count);
         // read domain sees reset only after its synchronizer
         if (i >= 3) begin
            check_value("out_valid", 0, out_valid);
         end
      end
      rst_n = 1'b1;
      repeat (5) begin
         @(negedge clk_in);
         check_outputs_idle();
      end
   endtask

   task test_single_packet();
      send_packet(5);
      wait_idle("a single packet");
      check_value("drop_count", 0, drop_count);
   endtask

   task test_store_and_forward();
      pkt_word_t w;
      int        n;
      pkt_buf.delete();
      for (int i = 0; i < 3; i++) begin
         w = make_word(1'b0);
         pkt_buf.push_back(w);
         drive_word(w);
      end
      end_input();
      for (int i = 0; i < 20; i++) begin
         @(negedge clk_out);
         check_value("out_valid before tlast", 0, out_valid);
      end
      w = make_word(1'b1);
      pkt_buf.push_back(w);
      drive_word(w);
      end_input();
      queue_packet();
      n = 0;
      while (out_valid !== 1'b1) begin
         @(negedge clk_out);
         n++;
         if (n > 20) begin
            report_failure("out_valid did not rise after the packet was completed");
         end
      end
      wait_idle("the store-and-forward packet");
   endtask

   task test_backpressure();
      int len;
      int n;
      ready_random = 1'b1;
      for (int p = 0; p < 20; p++) begin
         len = (lcg() >> 16) % 12 + 1;
         send_packet(len);
         // keep the backlog well below the depth so nothing drops
         n = 0;
         while (exp_q.size() > 16) begin
            @(negedge clk_out);
            n++;
            if (n > 1000) begin
               report_failure("timeout while the backlog drained under back-pressure");
            end
         end
      end
      set_ready(1'b1);
      wait_idle("the back-pressure packets");
   endtask

   task test_overflow_discard();
      set_ready(1'b0);
      track_occ    = 1'b1;
      stored_words = 0;
      send_packet(30);
      send_packet(30);
      send_packet(10);
      check_value("drop_count after overflow", 1, drop_count);
      track_occ = 1'b0;
      set_ready(1'b1);
      wait_idle("the packets stored before the overflow");
      send_packet(4);
      wait_idle("the packet after the overflow");
      check_value("drop_count", 1, drop_count);
   endtask

   task test_flow_ctl();
      int n;
      set_ready(1'b0);
      // park one word in the output register so memory starts empty
      send_packet(1);
      n = 0;
      while (out_valid !== 1'b1) begin
         @(negedge clk_out);
         n++;
         if (n > 20) begin
            report_failure("out_valid did not rise for the parked word");
         end
      end
      repeat (6) @(posedge clk_in);
      #5;
      flow_ctl_thresh = 10;
      send_packet(10);
      for (int i = 0; i < 4; i++) begin
         @(negedge clk_in);
         check_value("flow_ctl at threshold", 0, flow_ctl);
      end
      send_packet(1);
      n = 0;
      while (flow_ctl !== 1'b1) begin
         @(negedge clk_in);
         n++;
         if (n > 2) begin
            report_failure("flow_ctl did not rise above the threshold in time");
         end
      end
      set_ready(1'b1);
      n = 0;
      while (flow_ctl !== 1'b0) begin
         @(negedge clk_in);
         n++;
         if (n > 100) begin
            report_failure("flow_ctl did not fall after draining");
         end
      end
      wait_idle("the flow control packets");
      @(posedge clk_in);
      #5;
      flow_ctl_thresh = CNT_WID'(FIFO_DEPTH);
   endtask

   initial begin
      rst_n           = 1'b0;
      in_valid        = 1'b0;
      in_word         = '0;
      flow_ctl_thresh = CNT_WID'(FIFO_DEPTH);
      out_ready       = 1'b1;
      track_occ       = 1'b0;
      ready_random    = 1'b0;
      stored_words    = 0;
      exp_drops       = 0;
      held_valid      = 1'b0;
      held_word       = '0;
      test_reset();
      test_single_packet();
      test_store_and_forward();
      test_backpressure();
      test_overflow_discard();
      test_flow_ctl();
      if (exp_q.size() == 0 && drop_count == exp_drops) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         report_failure("words or drops were left unaccounted for at the end");
      end
   end

endmodule

// File: tb.f
hdl/pkt_fifo_pkg.sv
hdl/pkt_gray_sync.sv
hdl/pkt_dual_clock_mem.sv
hdl/pkt_ingress_discard.sv
hdl/pkt_egress.sv
hdl/pkt_fifo_async.sv
verification/tb_pkt_fifo_async.sv

// File: Bender.yml
package:
  name: pkt_fifo_async

sources:
  - files:
      - hdl/pkt_fifo_pkg.sv
      - hdl/pkt_gray_sync.sv
      - hdl/pkt_dual_clock_mem.sv
      - hdl/pkt_ingress_discard.sv
      - hdl/pkt_egress.sv
      - hdl/pkt_fifo_async.sv
  - target: test
    files:
      - verification/tb_pkt_fifo_async.sv
